// ==== rob_cfg.svh ====
`ifndef ROB_CFG_SVH
`define ROB_CFG_SVH

// number of entries and index width
`define ROB_DEPTH 16
`define ROB_IDX_W 4

// payload widths
`define ROB_DATA_W 32
`define ROB_ADDR_W 32
`define ROB_REG_W 5
`define ROB_SHAMT_W 5

`endif

// ==== rob_pkg.sv ====
`include "rob_cfg.svh"

package rob_pkg;

  typedef logic [`ROB_IDX_W-1:0] rob_idx_t;

  // wrap bit tells full from empty
  typedef struct packed {
    logic     wrap;
    rob_idx_t idx;
  } rob_ptr_t;

  typedef enum logic [3:0] {
    op_nop,
    op_add,
    op_sub,
    op_and,
    op_or,
    op_xor,
    op_nor,
    op_slt,
    op_sll,
    op_srl,
    op_sra,
    op_lui
  } rob_op_e;

  typedef enum logic [2:0] {
    exc_none,
    exc_overflow,
    exc_addr_err,
    exc_syscall,
    exc_break
  } rob_exc_e;

  // what issue needs to dispatch the instruction
  typedef struct packed {
    rob_op_e                 op;
    logic [`ROB_SHAMT_W-1:0] shamt;
    logic                    ref_1;
    logic                    ref_2;
    logic [`ROB_DATA_W-1:0]  operand_1;
    logic [`ROB_DATA_W-1:0]  operand_2;
    logic [`ROB_ADDR_W-1:0]  pc;
  } rob_issue_t;

  typedef struct packed {
    logic                  reg_write_en;
    logic [`ROB_REG_W-1:0] reg_addr;
    logic                  is_delayslot;
  } rob_dest_t;

  typedef struct packed {
    logic [`ROB_DATA_W-1:0] data;
    rob_exc_e               exc;
  } rob_result_t;

  typedef struct packed {
    rob_dest_t   dest;
    rob_result_t result;
  } rob_commit_t;

endpackage

// ==== rob_entry_array.sv ====
`timescale 1ns/1ps

`include "rob_cfg.svh"

module rob_entry_array
  import rob_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  // allocation at the tail
  input  logic        entry_write_en,
  input  rob_idx_t    tail_idx,
  input  rob_issue_t  write_issue,
  input  rob_dest_t   write_dest,
  input  rob_exc_e    write_exc,
  // writeback from execution
  input  logic        update_en,
  input  rob_idx_t    update_idx,
  input  rob_result_t update_result,
  // stored entries
  output rob_issue_t  issue_q  [`ROB_DEPTH],
  output rob_dest_t   dest_q   [`ROB_DEPTH],
  output rob_result_t result_q [`ROB_DEPTH],
  output logic [`ROB_DEPTH-1:0] done_q
);

  logic [`ROB_DEPTH-1:0] wr_sel;
  logic [`ROB_DEPTH-1:0] upd_sel;

  for (genvar i = 0; i < `ROB_DEPTH; i++) begin : g_entry

    assign wr_sel[i]  = entry_write_en && (tail_idx == rob_idx_t'(i));
    assign upd_sel[i] = update_en && (update_idx == rob_idx_t'(i));

    always_ff @(posedge clk) begin
      if (wr_sel[i]) begin
        issue_q[i] <= write_issue;
        dest_q[i]  <= write_dest;
      end
    end

    // a fresh entry carries only the front-end exception
    always_ff @(posedge clk) begin
      if (wr_sel[i]) begin
        result_q[i] <= '{data: '0, exc: write_exc};
      end else if (upd_sel[i]) begin
        result_q[i] <= update_result;
      end
    end

    always_ff @(posedge clk) begin
      if (!rst) begin
        done_q[i] <= 1'b0;
      end else if (wr_sel[i]) begin
        done_q[i] <= 1'b0;
      end else if (upd_sel[i]) begin
        done_q[i] <= 1'b1;
      end
    end

  end

endmodule

// ==== rob_ptr_ctrl.sv ====
`timescale 1ns/1ps

`include "rob_cfg.svh"

module rob_ptr_ctrl
  import rob_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     write_en,
  input  logic     read_en,
  input  logic     commit_en,
  input  logic     erase_en,
  input  rob_idx_t erase_idx,
  input  logic     update_en,
  input  rob_idx_t update_idx,
  input  logic     head_done,
  output rob_idx_t head_idx,
  output rob_idx_t read_idx,
  output rob_idx_t tail_idx,
  output logic     can_write,
  output logic     can_read,
  output logic     can_commit,
  output logic     entry_write_en
);

  rob_ptr_t head_ptr, read_ptr, tail_ptr;
  rob_ptr_t head_adv, read_adv, erase_ptr;
  rob_ptr_t read_next, tail_next;
  logic [`ROB_IDX_W:0] used;
  logic [`ROB_IDX_W:0] read_off, erase_off;

  assign head_idx = head_ptr.idx;
  assign read_idx = read_ptr.idx;
  assign tail_idx = tail_ptr.idx;

  // erase wins over a write in the same cycle
  assign entry_write_en = write_en && !erase_en;

  assign used       = tail_ptr - head_ptr;
  assign can_write  = used < `ROB_DEPTH;
  assign can_read   = (read_ptr != tail_ptr) || entry_write_en;
  assign can_commit = (used != '0) &&
                      (head_done || (update_en && update_idx == head_ptr.idx));

  always_comb begin
    head_adv = commit_en ? head_ptr + 1'b1 : head_ptr;
    read_adv = read_en ? read_ptr + 1'b1 : read_ptr;

    // an index below the head lies one lap ahead of it
    erase_ptr.idx  = erase_idx;
    erase_ptr.wrap = (erase_idx < head_adv.idx) ? ~head_adv.wrap : head_adv.wrap;

    tail_next = erase_en ? erase_ptr : (entry_write_en ? tail_ptr + 1'b1 : tail_ptr);

    // distances from head decide whether read is beyond the new tail
    read_off  = read_adv - head_adv;
    erase_off = erase_ptr - head_adv;
    read_next = (erase_en && read_off > erase_off) ? erase_ptr : read_adv;
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      head_ptr <= '0;
      read_ptr <= '0;
      tail_ptr <= '0;
    end else begin
      head_ptr <= head_adv;
      read_ptr <= read_next;
      tail_ptr <= tail_next;
    end
  end

endmodule

// ==== rob_read_port.sv ====
`timescale 1ns/1ps

`include "rob_cfg.svh"

module rob_read_port
  import rob_pkg::*;
(
  input  logic       read_en,
  input  logic       entry_write_en,
  input  rob_idx_t   read_idx,
  input  rob_idx_t   tail_idx,
  input  rob_issue_t issue_q [`ROB_DEPTH],
  input  rob_issue_t write_issue,
  output rob_issue_t read_issue
);

  logic fwd_write;

  // entry being allocated right now is the one issue wants
  assign fwd_write = entry_write_en && (read_idx == tail_idx);

  always_comb begin
    if (!read_en) begin
      read_issue = '0;
    end else if (fwd_write) begin
      read_issue = write_issue;
    end else begin
      read_issue = issue_q[read_idx];
    end
  end

endmodule

// ==== rob_commit_port.sv ====
`timescale 1ns/1ps

`include "rob_cfg.svh"

module rob_commit_port
  import rob_pkg::*;
(
  input  logic        commit_en,
  input  rob_idx_t    head_idx,
  input  logic        update_en,
  input  rob_idx_t    update_idx,
  input  rob_dest_t   dest_q   [`ROB_DEPTH],
  input  rob_result_t result_q [`ROB_DEPTH],
  input  rob_result_t update_result,
  output rob_commit_t commit_data
);

  logic        fwd_update;
  rob_result_t head_result;

  // writeback landing on the head this cycle
  assign fwd_update  = update_en && (update_idx == head_idx);
  assign head_result = fwd_update ? update_result : result_q[head_idx];

  always_comb begin
    if (commit_en) begin
      commit_data.dest   = dest_q[head_idx];
      commit_data.result = head_result;
    end else begin
      commit_data = '0;
    end
  end

endmodule

// ==== reorder_buffer.sv ====
`timescale 1ns/1ps

`include "rob_cfg.svh"

module reorder_buffer
  import rob_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  // write
  input  logic        write_en,
  input  rob_issue_t  write_issue,
  input  rob_dest_t   write_dest,
  input  rob_exc_e    write_exc,
  output logic        can_write,
  output rob_idx_t    write_idx,
  // read
  input  logic        read_en,
  output logic        can_read,
  output rob_idx_t    read_idx,
  output rob_issue_t  read_issue,
  // update
  input  logic        update_en,
  input  rob_idx_t    update_idx,
  input  rob_result_t update_result,
  // commit
  input  logic        commit_en,
  output logic        can_commit,
  output rob_commit_t commit_data,
  // erase
  input  logic        erase_en,
  input  rob_idx_t    erase_idx
);

  rob_idx_t    head_idx;
  rob_idx_t    tail_idx;
  logic        entry_write_en;
  rob_issue_t  issue_q  [`ROB_DEPTH];
  rob_dest_t   dest_q   [`ROB_DEPTH];
  rob_result_t result_q [`ROB_DEPTH];
  logic [`ROB_DEPTH-1:0] done_q;

  assign write_idx = tail_idx;

  rob_ptr_ctrl u_ptr_ctrl (
    .clk            (clk),
    .rst            (rst),
    .write_en       (write_en),
    .read_en        (read_en),
    .commit_en      (commit_en),
    .erase_en       (erase_en),
    .erase_idx      (erase_idx),
    .update_en      (update_en),
    .update_idx     (update_idx),
    .head_done      (done_q[head_idx]),
    .head_idx       (head_idx),
    .read_idx       (read_idx),
    .tail_idx       (tail_idx),
    .can_write      (can_write),
    .can_read       (can_read),
    .can_commit     (can_commit),
    .entry_write_en (entry_write_en)
  );

  rob_entry_array u_entry_array (
    .clk            (clk),
    .rst            (rst),
    .entry_write_en (entry_write_en),
    .tail_idx       (tail_idx),
    .write_issue    (write_issue),
    .write_dest     (write_dest),
    .write_exc      (write_exc),
    .update_en      (update_en),
    .update_idx     (update_idx),
    .update_result  (update_result),
    .issue_q        (issue_q),
    .dest_q         (dest_q),
    .result_q       (result_q),
    .done_q         (done_q)
  );

  rob_read_port u_read_port (
    .read_en        (read_en),
    .entry_write_en (entry_write_en),
    .read_idx       (read_idx),
    .tail_idx       (tail_idx),
    .issue_q        (issue_q),
    .write_issue    (write_issue),
    .read_issue     (read_issue)
  );

  rob_commit_port u_commit_port (
    .commit_en      (commit_en),
    .head_idx       (head_idx),
    .update_en      (update_en),
    .update_idx     (update_idx),
    .dest_q         (dest_q),
    .result_q       (result_q),
    .update_result  (update_result),
    .commit_data    (commit_data)
  );

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk,
  output logic rst
);

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // reset held low through five rising edges
  initial begin
    rst = 1'b0;
    repeat (5) @(posedge clk);
    rst <= 1'b1;
  end

endmodule

// ==== reorder_buffer_assertions.sv ====
`timescale 1ns/1ps

module reorder_buffer_assertions (
  input logic clk,
  input logic rst,
  input logic write_en,
  input logic can_write,
  input logic read_en,
  input logic can_read,
  input logic commit_en,
  input logic can_commit
);

  // strobes only while the channel is ready
  write_ready: assert property (@(posedge clk) disable iff (!rst) write_en |-> can_write)
    else $error("write_en high while can_write is low");

  read_ready: assert property (@(posedge clk) disable iff (!rst) read_en |-> can_read)
    else $error("read_en high while can_read is low");

  commit_ready: assert property (@(posedge clk) disable iff (!rst) commit_en |-> can_commit)
    else $error("commit_en high while can_commit is low");

  // buffer comes out of reset empty
  reset_empty: assert property (@(posedge clk) $rose(rst) |-> (!can_read && !can_commit))
    else $error("can_read or can_commit high right after reset");

endmodule

bind reorder_buffer reorder_buffer_assertions u_assertions (
  .clk        (clk),
  .rst        (rst),
  .write_en   (write_en),
  .can_write  (can_write),
  .read_en    (read_en),
  .can_read   (can_read),
  .commit_en  (commit_en),
  .can_commit (can_commit)
);

// ==== reorder_buffer_tb.sv ====
`timescale 1ns/1ps

`include "rob_cfg.svh"

module reorder_buffer_tb
  import rob_pkg::*;
();

  // limit well above the length of all tests
  localparam int max_cycles = 2000;

  typedef struct packed {
    rob_issue_t  issue;
    rob_dest_t   dest;
    rob_result_t result;
    logic        done;
  } model_entry_t;

  logic        clk;
  logic        rst;
  logic        write_en;
  rob_issue_t  write_issue;
  rob_dest_t   write_dest;
  rob_exc_e    write_exc;
  logic        can_write;
  rob_idx_t    write_idx;
  logic        read_en;
  logic        can_read;
  rob_idx_t    read_idx;
  rob_issue_t  read_issue;
  logic        update_en;
  rob_idx_t    update_idx;
  rob_result_t update_result;
  logic        commit_en;
  logic        can_commit;
  rob_commit_t commit_data;
  logic        erase_en;
  rob_idx_t    erase_idx;

  integer       seed = 32'h41fa5581;
  int           cycle_cnt = 0;
  model_entry_t model_q[$];
  int           head_pos = 0;
  int           read_off = 0;

  tb_clk_gen u_clk_gen (
    .clk (clk),
    .rst (rst)
  );

  reorder_buffer DUT (.*);

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= max_cycles) begin
      stop_run("timeout: tests did not finish within the cycle limit");
    end
  end

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic compare_flag(input string what, input bit got, input bit exp);
    if (got !== exp) begin
      stop_run($sformatf("Fail at %0t: %s is %0b, expected %0b", $time, what, got, exp));
    end
  endtask

  task automatic compare_idx(input string what, input rob_idx_t got, input rob_idx_t exp);
    if (got !== exp) begin
      stop_run($sformatf("Fail at %0t: %s is %0d, expected %0d", $time, what, got, exp));
    end
  endtask

  task automatic compare_issue(input string what, input rob_issue_t got, input rob_issue_t exp);
    if (got !== exp) begin
      stop_run($sformatf("Fail at %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic compare_commit(input string what, input rob_commit_t got,
                                input rob_commit_t exp);
    if (got !== exp) begin
      stop_run($sformatf("Fail at %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  function automatic rob_exc_e rand_exc();
    logic [31:0] r;
    r = $random(seed);
    return (r[2:0] <= exc_break) ? rob_exc_e'(r[2:0]) : exc_none;
  endfunction

  function automatic rob_issue_t rand_issue();
    rob_issue_t  iss;
    logic [31:0] r;
    r = $random(seed);
    iss.op        = (r[3:0] <= op_lui) ? rob_op_e'(r[3:0]) : op_add;
    iss.shamt     = r[8:4];
    iss.ref_1     = r[9];
    iss.ref_2     = r[10];
    iss.operand_1 = $random(seed);
    iss.operand_2 = $random(seed);
    iss.pc        = $random(seed);
    iss.pc[1:0]   = 2'b00;
    return iss;
  endfunction

  function automatic rob_dest_t rand_dest();
    rob_dest_t   dst;
    logic [31:0] r;
    r = $random(seed);
    dst.reg_write_en = r[0];
    dst.reg_addr     = r[5:1];
    dst.is_delayslot = r[6];
    return dst;
  endfunction

  function automatic rob_result_t rand_result();
    rob_result_t res;
    res.data = $random(seed);
    res.exc  = rand_exc();
    return res;
  endfunction

  // one clock of stimulus and checks
  // offsets count from the head
  task automatic run_cycle(input bit wr, input bit rd, input bit upd, input int upd_off,
                           input bit cm, input bit er, input int erase_off);
    rob_issue_t   iss;
    rob_dest_t    dst;
    rob_exc_e     exc;
    rob_result_t  res;
    rob_idx_t     eidx;
    model_entry_t ent;
    int           size;
    int           new_size;
    bit           head_upd;
    bit           head_done;
    rob_issue_t   exp_issue;
    rob_commit_t  exp_commit;

    iss  = rand_issue();
    dst  = rand_dest();
    exc  = rand_exc();
    res  = rand_result();
    eidx = rob_idx_t'(head_pos + erase_off);

    @(posedge clk);
    write_en      <= wr;
    write_issue   <= iss;
    write_dest    <= dst;
    write_exc     <= exc;
    read_en       <= rd;
    update_en     <= upd;
    update_idx    <= rob_idx_t'(head_pos + upd_off);
    update_result <= res;
    commit_en     <= cm;
    erase_en      <= er;
    erase_idx     <= eidx;
    @(negedge clk);

    size      = model_q.size();
    head_upd  = upd && (upd_off == 0);
    head_done = 1'b0;
    if (size > 0) begin
      head_done = model_q[0].done;
    end
    compare_flag("can_write", can_write, size < `ROB_DEPTH);
    compare_flag("can_read", can_read, (read_off < size) || (wr && !er));
    compare_flag("can_commit", can_commit, (size > 0) && (head_done || head_upd));
    compare_idx("write_idx", write_idx, rob_idx_t'(head_pos + size));
    compare_idx("read_idx", read_idx, rob_idx_t'(head_pos + read_off));

    exp_issue = '0;
    if (rd) begin
      exp_issue = (read_off < size) ? model_q[read_off].issue : iss;
    end
    compare_issue("read_issue", read_issue, exp_issue);

    exp_commit = '0;
    if (cm) begin
      exp_commit.dest   = model_q[0].dest;
      exp_commit.result = head_upd ? res : model_q[0].result;
    end
    compare_commit("commit_data", commit_data, exp_commit);

    if (upd) begin
      ent = model_q[upd_off];
      ent.result = res;
      ent.done = 1'b1;
      model_q[upd_off] = ent;
    end
    if (rd) begin
      read_off++;
    end
    if (cm) begin
      ent = model_q.pop_front();
      head_pos = (head_pos + 1) % `ROB_DEPTH;
      read_off--;
    end
    if (er) begin
      new_size = (int'(eidx) - head_pos + `ROB_DEPTH) % `ROB_DEPTH;
      while (model_q.size() > new_size) begin
        ent = model_q.pop_back();
      end
      if (read_off > new_size) begin
        read_off = new_size;
      end
    end else if (wr) begin
      ent.issue       = iss;
      ent.dest        = dst;
      ent.result.data = '0;
      ent.result.exc  = exc;
      ent.done        = 1'b0;
      model_q.push_back(ent);
    end
  endtask

  task automatic idle_cycle();
    run_cycle(0, 0, 0, 0, 0, 0, 0);
  endtask

  task automatic write_entries(input int n);
    repeat (n) run_cycle(1, 0, 0, 0, 0, 0, 0);
  endtask

  task automatic read_entries(input int n);
    repeat (n) run_cycle(0, 1, 0, 0, 0, 0, 0);
  endtask

  // issue what is left, then retire with the writeback forwarded
  task automatic drain();
    while (read_off < model_q.size()) begin
      run_cycle(0, 1, 0, 0, 0, 0, 0);
    end
    while (model_q.size() > 0) begin
      run_cycle(0, 0, 1, 0, 1, 0, 0);
    end
  endtask

  task automatic test_reset_state();
    idle_cycle();
    compare_flag("reset can_write", can_write, 1'b1);
    compare_flag("reset can_read", can_read, 1'b0);
    compare_flag("reset can_commit", can_commit, 1'b0);
    compare_idx("reset write_idx", write_idx, '0);
  endtask

  task automatic test_write_read_order();
    write_entries(5);
    read_entries(5);
    // read meets the write at the tail
    run_cycle(1, 1, 0, 0, 0, 0, 0);
    drain();
  endtask

  task automatic test_full_buffer();
    write_entries(`ROB_DEPTH);
    idle_cycle();
    compare_flag("full can_write", can_write, 1'b0);
    run_cycle(0, 1, 0, 0, 0, 0, 0);
    run_cycle(0, 0, 1, 0, 0, 0, 0);
    run_cycle(0, 0, 0, 0, 1, 0, 0);
    idle_cycle();
    compare_flag("can_write after commit", can_write, 1'b1);
    drain();
  endtask

  task automatic test_out_of_order();
    write_entries(10);
    read_entries(10);
    for (int i = 9; i >= 1; i--) begin
      run_cycle(0, 0, 1, i, 0, 0, 0);
      compare_flag("can_commit with head pending", can_commit, 1'b0);
    end
    // head finishes in the same cycle it retires
    run_cycle(0, 0, 1, 0, 1, 0, 0);
    repeat (9) run_cycle(0, 0, 0, 0, 1, 0, 0);
  endtask

  task automatic test_erase();
    write_entries(8);
    read_entries(3);
    // write alongside erase is dropped
    run_cycle(1, 0, 0, 0, 0, 1, 2);
    idle_cycle();
    compare_idx("write_idx after erase", write_idx, rob_idx_t'(head_pos + 2));
    compare_flag("can_read after erase", can_read, 1'b0);
    write_entries(1);
    read_entries(1);
    drain();
  endtask

  initial begin
    write_en      <= 1'b0;
    write_issue   <= '0;
    write_dest    <= '0;
    write_exc     <= exc_none;
    read_en       <= 1'b0;
    update_en     <= 1'b0;
    update_idx    <= '0;
    update_result <= '0;
    commit_en     <= 1'b0;
    erase_en      <= 1'b0;
    erase_idx     <= '0;
    wait (rst === 1'b1);
    test_reset_state();
    test_write_read_order();
    test_full_buffer();
    test_out_of_order();
    test_erase();
    $display("*** PASSED ***");
    $finish;
  end

endmodule

// ==== reorder_buffer.f ====
+incdir+.
rob_pkg.sv
rob_entry_array.sv
rob_ptr_ctrl.sv
rob_read_port.sv
rob_commit_port.sv
reorder_buffer.sv
tb_clk_gen.sv
reorder_buffer_assertions.sv
reorder_buffer_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP       := reorder_buffer_tb
FILELIST  := reorder_buffer.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)
